//--- design/pov_pkg.sv
// geometry is fixed when the design is built: one 64x64 sphere image, and colour bits are all set or all clear
package pov_pkg;

    localparam int ROTATIONAL_RES = 1024;             // angle steps per revolution
    localparam int SCAN_RATE      = 32;               // column pairs per image
    localparam int NUM_COLS       = 64;               // image width in columns
    localparam int NUM_ROWS       = 64;               // LEDs per blade column
    localparam int RGB_RES        = 9;                // colour bits per pixel
    localparam int RADIUS         = 20;               // sphere radius in pixels
    localparam int CENTER_X       = NUM_COLS / 2;
    localparam int CENTER_Y       = NUM_ROWS / 2;

    localparam int THETA_W        = $clog2(ROTATIONAL_RES);
    localparam int HALF_REV       = ROTATIONAL_RES >> 1; // polarity flips here
    localparam int PERIOD_W       = 24;               // covers revolutions up to 16M cycles
    localparam int STEP_W         = PERIOD_W - THETA_W;  // width of period / ROTATIONAL_RES
    localparam int COL_W          = $clog2(SCAN_RATE);

    // each lane carries one full column, row by row
    localparam int LANE_BITS      = NUM_ROWS * RGB_RES;
    localparam int BIT_CNT_W      = $clog2(LANE_BITS);

    typedef logic [THETA_W-1:0] theta_t;              // discretized blade angle
    typedef logic [COL_W-1:0]   col_idx_t;            // column pair index, 0 to 31
    typedef logic [RGB_RES-1:0] pixel_t;
    typedef pixel_t [NUM_ROWS-1:0] column_t;          // row 0 sits in the low slot

    localparam theta_t THETA_MAX = theta_t'(ROTATIONAL_RES - 1); // saturation point

    // request from the sequencer to the sphere frame stage
    typedef struct packed {
        theta_t       dtheta;        // angle sampled when the request was formed
        col_idx_t     column_index1; // left column of the pair
        logic [COL_W:0] column_index2; // always CENTER_X + column_index1
    } col_req_t;

    // finished column pair from the frame stage to the shifter
    typedef struct packed {
        column_t  col2;              // goes out on lane 1
        column_t  col1;              // goes out on lane 0
        theta_t   dtheta;            // tag, shown on frame_dtheta at the latch
        col_idx_t column_index1;     // tag, shown on frame_column at the latch
    } col_pair_t;

endpackage

//--- design/angle_tracker.sv
// dtheta is only meaningful once two hall pulses have arrived, and periods under 1024 cycles step every cycle
`timescale 1ns/1ps

module angle_tracker
    import pov_pkg::*;
(
    input  logic   clk_in,
    input  logic   arst_n,
    input  logic   hall,    // one pulse per revolution, asynchronous to clk_in
    output theta_t dtheta   // angle since the last pulse, saturating
);

    logic                hall_meta, hall_sync, hall_prev;
    logic                hall_rise;
    logic [PERIOD_W-1:0] elapsed;   // cycles since the last detected edge
    logic [PERIOD_W-1:0] period;    // last full revolution in cycles
    logic [STEP_W-1:0]   step;      // cycles per angle step
    logic [STEP_W-1:0]   sub_cnt;
    logic                seen_edge; // at least one edge detected
    logic                period_ok; // a full period has been measured
    logic                expire;

    assign hall_rise = hall_sync & ~hall_prev;       // edge acts on the third clock after hall rises
    assign step      = period[PERIOD_W-1:THETA_W];   // period / ROTATIONAL_RES

    // a step of 0 or 1 means the angle moves every cycle
    assign expire = period_ok && (({1'b0, sub_cnt} + 1'b1) >= {1'b0, step});

    // two flops against metastability, one more to find the rising edge
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            hall_meta <= 1'b0;
            hall_sync <= 1'b0;
            hall_prev <= 1'b0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
            hall_prev <= hall_sync;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            elapsed   <= '0;
            period    <= '0;
            seen_edge <= 1'b0;
            period_ok <= 1'b0;
        end else if (hall_rise) begin
            elapsed   <= '0;
            seen_edge <= 1'b1;
            if (seen_edge) begin // the first edge only starts the count
                period    <= elapsed;
                period_ok <= 1'b1;
            end
        end else if (elapsed != '1) begin
            elapsed <= elapsed + 1'b1; // holds at full scale if the blade stalls
        end
    end

    // step sub-counter and the angle it drives
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            sub_cnt <= '0;
            dtheta  <= '0;
        end else if (hall_rise) begin
            sub_cnt <= '0;
            dtheta  <= '0;   // new revolution starts at angle 0
        end else if (expire) begin
            sub_cnt <= '0;
            if (dtheta != THETA_MAX) begin
                dtheta <= dtheta + 1'b1;
            end
        end else if (period_ok) begin
            sub_cnt <= sub_cnt + 1'b1;
        end
    end

    // a slow revolution parks the angle at the top instead of wrapping to 0
    a_dtheta_saturates: assert property (@(posedge clk_in) disable iff (!arst_n)
        (dtheta == THETA_MAX && !hall_rise) |=> dtheta == THETA_MAX)
        else $error("dtheta wrapped without a hall edge");

    a_dtheta_restart: assert property (@(posedge clk_in) disable iff (!arst_n)
        hall_rise |=> dtheta == '0)
        else $error("dtheta did not restart after a hall edge");

endmodule

//--- design/column_sequencer.sv
// columns run 0 to 31 forever with no frame start marker, and the angle is sampled when a request forms
`timescale 1ns/1ps

module column_sequencer
    import pov_pkg::*;
(
    input  logic     clk_in,
    input  logic     arst_n,
    input  theta_t   dtheta,    // level from the angle tracker
    input  logic     req_ready,
    output logic     req_valid,
    output col_req_t req
);

    col_idx_t col_cnt;   // column pair currently offered
    theta_t   dtheta_q;  // angle captured with that request
    logic     take;      // request leaves on this edge

    assign take = req_valid && req_ready;

    // valid stays low for the first cycle out of reset, then never drops
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
            col_cnt   <= '0;
        end else begin
            req_valid <= 1'b1;
            if (take) begin
                col_cnt <= col_cnt + 1'b1; // 5 bits, so 31 rolls over to 0
            end
        end
    end

    // a fresh angle is taken whenever a new request is formed
    always_ff @(posedge clk_in) begin
        if (!req_valid || take) begin
            dtheta_q <= dtheta;
        end
    end

    always_comb begin
        req.dtheta        = dtheta_q;
        req.column_index1 = col_cnt;
        req.column_index2 = (COL_W + 1)'(CENTER_X) + {1'b0, col_cnt}; // mirror half
    end

    // stalled requests must not change under the frame stage
    a_req_stable: assert property (@(posedge clk_in) disable iff (!arst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("request changed while stalled");

endmodule

//--- design/color_sphere_frame.sv
// only the sphere image is drawn, lit pixels are all ones or all zeros, and column_index2 must be CENTER_X + column_index1
`timescale 1ns/1ps

module color_sphere_frame
    import pov_pkg::*;
(
    input  logic      clk_in,
    input  logic      arst_n,
    input  logic      req_valid,
    input  col_req_t  req,
    input  logic      pair_ready,
    output logic      req_ready,
    output logic      pair_valid,
    output col_pair_t pair
);

    column_t column1, column2;  // combinational result for the request at the input
    logic    first_half;        // blade is in the first half of the revolution
    logic    load;

    // a new pair is taken when the register is empty or drains on the same edge
    assign req_ready = !pair_valid || pair_ready;
    assign load      = req_valid && req_ready;

    assign first_half = (int'(req.dtheta) < HALF_REV);

    always_comb begin
        int x1;
        int x2;
        int y_offset;
        int dist1;
        int dist2;

        x1 = CENTER_X - int'(req.column_index1); // left half, always 1 to 32
        x2 = int'(req.column_index2) - CENTER_X; // right half, 0 to 31

        for (int y = 0; y < NUM_ROWS; y++) begin
            // top half counts down to the centre, bottom half counts up from it
            if (y < CENTER_Y) begin
                y_offset = CENTER_Y - y;
            end else begin
                y_offset = y - CENTER_Y;
            end

            dist1 = x1 * x1 + y_offset * y_offset;
            dist2 = x2 * x2 + y_offset * y_offset;

            column1[y] = '0; // outside the circle stays dark
            column2[y] = '0;

            if (dist1 <= RADIUS * RADIUS) begin
                column1[y] = first_half ? '1 : '0;
            end
            if (dist2 <= RADIUS * RADIUS) begin
                column2[y] = first_half ? '0 : '1; // opposite polarity
            end
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pair_valid <= 1'b0;
        end else if (load) begin
            pair_valid <= 1'b1;
        end else if (pair_ready) begin
            pair_valid <= 1'b0; // taken with nothing behind it
        end
    end

    // pixel data and tags follow the request into the stage register
    always_ff @(posedge clk_in) begin
        if (load) begin
            pair.col1          <= column1;
            pair.col2          <= column2;
            pair.dtheta        <= req.dtheta;
            pair.column_index1 <= req.column_index1;
        end
    end

endmodule

//--- design/led_column_shifter.sv
// one pair at a time, 576 bits per lane at half the clock rate, so a pair takes 1154 cycles with the latch
`timescale 1ns/1ps

module led_column_shifter
    import pov_pkg::*;
(
    input  logic      clk_in,
    input  logic      arst_n,
    input  logic      pair_valid,
    input  col_pair_t pair,
    output logic      pair_ready,
    output logic      led_sclk,     // low for the first half of each bit, high for the second
    output logic [1:0] led_sdata,   // bit 0 carries column 1, bit 1 carries column 2
    output logic      led_latch,
    output theta_t    frame_dtheta,
    output col_idx_t  frame_column
);

    localparam int LAST_BIT = LANE_BITS - 1;

    logic [LANE_BITS-1:0] lane0_load, lane1_load; // pair reordered into send order
    logic [LANE_BITS-1:0] sh0, sh1;               // current bit sits at the MSB
    logic [BIT_CNT_W-1:0] bit_cnt;                // index of the bit now on the lanes
    logic                 shifting;
    logic                 accept;
    logic                 last_bit;
    logic                 advance;

    assign pair_ready = !shifting && !led_latch; // busy through the latch cycle too
    assign accept     = pair_valid && pair_ready;
    assign last_bit   = (bit_cnt == BIT_CNT_W'(LAST_BIT));
    assign advance    = shifting && led_sclk && !last_bit; // move on at the end of a high phase

    // row 0 goes first, so it lands at the top of the shift vector
    always_comb begin
        for (int y = 0; y < NUM_ROWS; y++) begin
            lane0_load[(NUM_ROWS - 1 - y) * RGB_RES +: RGB_RES] = pair.col1[y];
            lane1_load[(NUM_ROWS - 1 - y) * RGB_RES +: RGB_RES] = pair.col2[y];
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            sh0 <= lane0_load;
            sh1 <= lane1_load;
        end else if (advance) begin
            sh0 <= sh0 << 1;
            sh1 <= sh1 << 1;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            shifting     <= 1'b0;
            led_sclk     <= 1'b0;
            led_latch    <= 1'b0;
            led_sdata    <= '0;
            bit_cnt      <= '0;
            frame_dtheta <= '0;
            frame_column <= '0;
        end else begin
            led_latch <= 1'b0;                   // single-cycle pulse
            if (accept) begin
                shifting     <= 1'b1;
                led_sclk     <= 1'b0;
                bit_cnt      <= '0;
                led_sdata    <= {lane1_load[LAST_BIT], lane0_load[LAST_BIT]}; // row 0 MSB
                frame_dtheta <= pair.dtheta;     // tags held until the next pair
                frame_column <= pair.column_index1;
            end else if (shifting) begin
                if (!led_sclk) begin
                    led_sclk <= 1'b1;            // data has been stable for a full cycle
                end else if (last_bit) begin
                    led_sclk  <= 1'b0;
                    shifting  <= 1'b0;
                    led_latch <= 1'b1;           // the cycle after the last high phase
                    led_sdata <= '0;
                end else begin
                    led_sclk  <= 1'b0;
                    bit_cnt   <= bit_cnt + 1'b1;
                    led_sdata <= {sh1[LAST_BIT-1], sh0[LAST_BIT-1]}; // next bit
                end
            end
        end
    end

    // the latch must only follow the high phase of the final bit
    a_latch_after_last: assert property (@(posedge clk_in) disable iff (!arst_n)
        $rose(led_latch) |-> $past(shifting && led_sclk && last_bit))
        else $error("led_latch rose with bits still to shift");

endmodule

//--- design/pov_sphere_top.sv
// hall must pulse once per revolution, and the first valid angle comes only after the second pulse
`timescale 1ns/1ps

module pov_sphere_top
    import pov_pkg::*;
(
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       hall,          // raw sensor input
    output logic       led_sclk,
    output logic [1:0] led_sdata,     // lane 0 is the left column, lane 1 the mirror
    output logic       led_latch,
    output theta_t     frame_dtheta,  // angle tag of the pair just latched
    output col_idx_t   frame_column   // column tag of the pair just latched
);

    theta_t    dtheta;     // level, no handshake
    logic      req_valid, req_ready;
    col_req_t  req;
    logic      pair_valid, pair_ready;
    col_pair_t pair;

    angle_tracker angle_tracker_inst (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .hall   (hall),
        .dtheta (dtheta)
    );

    column_sequencer column_sequencer_inst (
        .clk_in    (clk_in),
        .arst_n    (arst_n),
        .dtheta    (dtheta),
        .req_ready (req_ready),
        .req_valid (req_valid),
        .req       (req)
    );

    // back-pressure from the shifter reaches the sequencer through here
    color_sphere_frame color_sphere_frame_inst (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .pair_ready (pair_ready),
        .req_ready  (req_ready),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    led_column_shifter led_column_shifter_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .pair_valid   (pair_valid),
        .pair         (pair),
        .pair_ready   (pair_ready),
        .led_sclk     (led_sclk),
        .led_sdata    (led_sdata),
        .led_latch    (led_latch),
        .frame_dtheta (frame_dtheta),
        .frame_column (frame_column)
    );

endmodule

//--- testbench/pov_sphere_model.svh
// model of the 64x64 sphere image and of the blade angle, meant for the fixed geometry in pov_pkg
`ifndef POV_SPHERE_MODEL_SVH
`define POV_SPHERE_MODEL_SVH

// lane 0 draws the left half of the sphere, lane 1 the mirror half
function automatic bit pixel_lit(input int col, input int lane, input int row);
    int x;
    int y;
    if (lane == 0) begin
        x = CENTER_X - col;   // left column lies this far from the centre
    end else begin
        x = col;              // mirror column sits col steps right of the centre
    end
    y = (row < CENTER_Y) ? CENTER_Y - row : row - CENTER_Y;
    return (x * x + y * y) <= RADIUS * RADIUS;
endfunction

// lane 0 is lit with ones during the first half revolution, lane 1 the other way round
function automatic pixel_t lit_value(input int dtheta, input int lane);
    bit first_half;
    first_half = dtheta < ROTATIONAL_RES / 2;
    if ((lane == 0) == first_half) begin
        return '1;
    end
    return '0;
endfunction

// the elapsed count restarts at 0 on an edge, so it ends one short of the edge spacing
function automatic int step_size(input int e_prev, input int e_last);
    int step;
    step = (e_last - e_prev - 1) >> THETA_W;
    if (step < 1) begin
        step = 1;             // very short revolutions advance the angle every cycle
    end
    return step;
endfunction

function automatic int angle_after(input int cycles, input int step);
    int angle;
    angle = cycles / step;
    if (angle > ROTATIONAL_RES - 1) begin
        angle = ROTATIONAL_RES - 1; // slow revolutions park at the top
    end
    return angle;
endfunction

`endif

//--- testbench/pov_sphere_tb.sv
// runs 300 frames against random hall periods of 40000 to 120000 cycles, fixed by the seed
`timescale 1ns/1ps

module pov_sphere_tb
    import pov_pkg::*;
();

    localparam int NUM_FRAMES  = 300;
    localparam int PAIR_CYCLES = 2 * LANE_BITS + 2;          // bits at half rate, latch, reload
    localparam int CYCLE_LIMIT = NUM_FRAMES * PAIR_CYCLES + 20000;
    // the angle is sampled two pair slots before its shift starts and shows at the latch a slot later
    localparam int SAMPLE_LAG  = 2 * PAIR_CYCLES + PAIR_CYCLES - 1;
    localparam int HALL_DELAY  = 3;                          // two sync flops and the edge detector
    localparam int HALL_HIGH   = 10;
    localparam int MIN_GAP     = 40000;
    localparam int GAP_SPAN    = 80001;
    localparam int ANGLE_TOL   = 2;

    logic       clk_in;
    logic       arst_n;
    logic       hall;
    logic       led_sclk;
    logic [1:0] led_sdata;
    logic       led_latch;
    theta_t     frame_dtheta;
    col_idx_t   frame_column;

    integer seed;
    int     cyc = 0;             // index of the current edge, read before it moves on
    int     edge_q[$];           // edges on which the tracker restarts the angle
    int     frame_cnt = 0;
    int     sclk_rises = 0;
    int     expected_col = 0;
    logic   sclk_prev = 1'b0;
    pixel_t pix0 [NUM_ROWS];     // column 1 as captured row by row
    pixel_t pix1 [NUM_ROWS];
    int     checks = 0;
    int     reset_err = 0;
    int     geom_err = 0;
    int     pol_err = 0;
    int     seq_err = 0;
    int     angle_err = 0;
    int     shape_err = 0;

    `include "pov_sphere_model.svh"

    pov_sphere_top pov_sphere_top_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .hall         (hall),
        .led_sclk     (led_sclk),
        .led_sdata    (led_sdata),
        .led_latch    (led_latch),
        .frame_dtheta (frame_dtheta),
        .frame_column (frame_column)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cyc <= cyc + 1;
    end

    function automatic int total_errors();
        return reset_err + geom_err + pol_err + seq_err + angle_err + shape_err;
    endfunction

    task automatic check_reset_outputs();
        checks++;
        if (led_sclk !== 1'b0 || led_sdata !== 2'b00 || led_latch !== 1'b0 ||
            frame_dtheta !== '0 || frame_column !== '0) begin
            reset_err++;
            $display("Mismatch at %0t: outputs not low in reset, sclk %b sdata %b latch %b",
                     $time, led_sclk, led_sdata, led_latch);
        end
    endtask

    task automatic capture_bit();
        int row;
        row = sclk_rises / RGB_RES;
        if (row < NUM_ROWS) begin
            pix0[row] = {pix0[row][RGB_RES-2:0], led_sdata[0]}; // MSB arrives first
            pix1[row] = {pix1[row][RGB_RES-2:0], led_sdata[1]};
        end
        sclk_rises++;
    endtask

    task automatic check_frame();
        pixel_t got;
        int     s;
        int     e_last;
        int     e_prev;
        int     n_edges;
        int     expected;
        int     diff;
        int     tol;

        checks += 2;
        if (sclk_rises != LANE_BITS) begin
            shape_err++;
            $display("Mismatch at %0t: frame %0d had %0d shift clock edges, expected %0d",
                     $time, frame_cnt, sclk_rises, LANE_BITS);
        end
        if (int'(frame_column) != expected_col) begin
            seq_err++;
            $display("Mismatch at %0t: frame_column %0d, expected %0d",
                     $time, frame_column, expected_col);
        end
        expected_col = (expected_col + 1) % SCAN_RATE;

        for (int row = 0; row < NUM_ROWS; row++) begin
            for (int lane = 0; lane < 2; lane++) begin
                got = (lane == 0) ? pix0[row] : pix1[row];
                checks++;
                if (!pixel_lit(frame_column, lane, row)) begin
                    if (got != '0) begin
                        geom_err++;  // outside the circle must be dark
                        $display("Mismatch at %0t: column %0d lane %0d row %0d lit as %h",
                                 $time, frame_column, lane, row, got);
                    end
                end else if (got != lit_value(frame_dtheta, lane)) begin
                    pol_err++;
                    $display("Mismatch at %0t: column %0d lane %0d row %0d is %h at angle %0d",
                             $time, frame_column, lane, row, got, frame_dtheta);
                end
            end
        end

        // find the last two tracker edges before the sequencer sampled the angle
        s       = cyc - SAMPLE_LAG;
        n_edges = 0;
        e_last  = 0;
        e_prev  = 0;
        foreach (edge_q[i]) begin
            if (edge_q[i] <= s - 1) begin
                e_prev = e_last;
                e_last = edge_q[i];
                n_edges++;
            end
        end
        if (n_edges < 2) begin
            expected = 0;    // no full period measured yet
            tol      = 0;
        end else begin
            expected = angle_after(s - 1 - e_last, step_size(e_prev, e_last));
            tol      = ANGLE_TOL;
        end
        diff = int'(frame_dtheta) - expected;
        checks++;
        if (diff > tol || diff < -tol) begin
            angle_err++;
            $display("Mismatch at %0t: frame_dtheta %0d, expected %0d within %0d",
                     $time, frame_dtheta, expected, tol);
        end
        frame_cnt++;
        sclk_rises = 0;
    endtask

    task automatic report_results();
        $display("geometry: %0d frames, %0d errors", frame_cnt, geom_err);
        $display("polarity: %0d frames, %0d errors", frame_cnt, pol_err);
        $display("sequence: %0d frames, %0d errors", frame_cnt, seq_err);
        $display("angle: %0d frames, %0d errors", frame_cnt, angle_err);
        $display("frame shape: %0d frames, %0d errors", frame_cnt, shape_err);
        $display("totals: %0d checks, %0d errors", checks, total_errors());
    endtask

    // outputs are read on the clock edge, where they hold the values of the previous cycle
    always @(posedge clk_in) begin
        if (arst_n) begin
            if (led_latch && led_sclk) begin
                shape_err++;
                $display("led_latch and led_sclk were high together at %0t", $time);
            end
            if (led_sclk && !sclk_prev) begin
                capture_bit();
            end
            if (led_latch) begin
                check_frame();
            end
            sclk_prev = led_sclk;
        end
    end

    // hall pulses start after reset with a fresh random period each revolution
    initial begin
        int gap;
        seed = 32'h49ca_e74a;
        wait (arst_n === 1'b1);
        forever begin
            gap = MIN_GAP + int'($unsigned($random(seed)) % GAP_SPAN);
            repeat (gap - HALL_HIGH) @(posedge clk_in);
            hall <= 1'b1;
            edge_q.push_back(cyc + HALL_DELAY);
            repeat (HALL_HIGH) @(posedge clk_in);
            hall <= 1'b0;
        end
    end

    initial begin
        arst_n = 1'b0;
        hall   = 1'b0;
        @(posedge clk_in);
        @(negedge clk_in);
        check_reset_outputs();
        @(posedge clk_in);
        arst_n <= 1'b1;     // released after two rising edges in reset
        $display("reset outputs: %0d errors", reset_err);
        while (frame_cnt < NUM_FRAMES && cyc < CYCLE_LIMIT) begin
            @(negedge clk_in);
        end
        report_results();
        if (frame_cnt < NUM_FRAMES) begin
            $display("Timeout: only %0d of %0d frames were latched within %0d cycles",
                     frame_cnt, NUM_FRAMES, CYCLE_LIMIT);
        end
        if (frame_cnt == NUM_FRAMES && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
design/pov_pkg.sv
design/angle_tracker.sv
design/column_sequencer.sv
design/color_sphere_frame.sv
design/led_column_shifter.sv
design/pov_sphere_top.sv
testbench/pov_sphere_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and decides the result from its output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module pov_sphere_tb -Mdir obj_dir

# a failing assertion may stop the simulator early, the output still decides
sim_out=$(./obj_dir/Vpov_sphere_tb) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "Test completed successfully"; then
    echo "run passed"
    exit 0
fi
echo "run failed"
exit 1
